// File: source/vga_pkg.sv
package vga_pkg;

	// pixel coordinate, wide enough for 640x480 totals
	typedef logic [10:0] coord_t;

	// bgr byte order, matching the DAC bus
	typedef struct packed {
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} rgb_t;

	typedef struct packed {
		coord_t     pos_x;
		coord_t     pos_y;
		logic [2:0] lives;
	} player_t;

	// decode to execute stage
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   valid;
		logic   hs;
		logic   vs;
		logic   frame_start;
	} scan_t;

	// execute to result stage
	typedef struct packed {
		logic valid;
		logic hs;
		logic vs;
		logic p1_sprite;
		logic p2_sprite;
		logic p1_lives;
		logic p2_lives;
	} hit_t;

	localparam int LIVES_MAX  = 5;
	localparam int SPRITE_W   = 16;
	localparam int SPRITE_H   = 16;
	localparam int LIVES_SIZE = 4;
	localparam int LIVES_STEP = 6;

	localparam rgb_t BG_COLOR     = '{b: 8'h55, g: 8'h55, r: 8'h55};
	localparam rgb_t P1_COLOR     = '{b: 8'h20, g: 8'h80, r: 8'hf0};
	localparam rgb_t P2_COLOR     = '{b: 8'hf0, g: 8'h90, r: 8'h30};
	localparam rgb_t LIVES1_COLOR = '{b: 8'h00, g: 8'h00, r: 8'h7c};
	localparam rgb_t LIVES2_COLOR = '{b: 8'haa, g: 8'haa, r: 8'haa};

endpackage

// File: source/scan_decoder.sv
`timescale 1ns/1ps

module scan_decoder import vga_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic  VGA_CLK_n,
	input  logic  iRST_n,
	output scan_t scan
);

	localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_BEG = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END = H_SYNC_BEG + H_SYNC;
	localparam int V_SYNC_BEG = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END = V_SYNC_BEG + V_SYNC;

	coord_t h_cnt;
	coord_t v_cnt;
	logic   line_end;
	logic   frame_end;
	logic   active;
	logic   hs_n;
	logic   vs_n;

	assign line_end  = (h_cnt == coord_t'(H_TOTAL - 1));
	assign frame_end = (v_cnt == coord_t'(V_TOTAL - 1));

	// position counters, line first then frame
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (line_end) begin
				h_cnt <= '0;
				if (frame_end)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// active area comes first on every line and in every frame
	assign active = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);

	// sync pulses are active low
	assign hs_n = !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END));
	assign vs_n = !((v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END));

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			scan.x           <= '0;
			scan.y           <= '0;
			scan.valid       <= 1'b0;
			scan.hs          <= 1'b1;
			scan.vs          <= 1'b1;
			scan.frame_start <= 1'b0;
		end else begin
			scan.x           <= h_cnt;
			scan.y           <= v_cnt;
			scan.valid       <= active;
			scan.hs          <= hs_n;
			scan.vs          <= vs_n;
			// one cycle marker at the top left corner
			scan.frame_start <= (h_cnt == '0) && (v_cnt == '0);
		end
	end

endmodule

// File: source/layer_hit_unit.sv
`timescale 1ns/1ps

module layer_hit_unit import vga_pkg::*; #(
	parameter int LIVES1_X = 16,
	parameter int LIVES2_X = 590,
	parameter int LIVES_Y  = 16
) (
	input  logic    VGA_CLK_n,
	input  logic    iRST_n,
	input  scan_t   scan,
	input  player_t p1,
	input  player_t p2,
	output hit_t    hits
);

	player_t p1_q;
	player_t p2_q;
	player_t p1_cur;
	player_t p2_cur;

	// rectangle test against the sprite's top left corner
	function automatic logic sprite_hit(coord_t x, coord_t y, player_t p);
		logic in_x;
		logic in_y;
		in_x = (x >= p.pos_x) && (int'(x) < int'(p.pos_x) + SPRITE_W);
		in_y = (y >= p.pos_y) && (int'(y) < int'(p.pos_y) + SPRITE_H);
		return in_x && in_y;
	endfunction

	// row of boxes, only the first lives of them are drawn
	function automatic logic lives_hit(coord_t x, coord_t y, int base_x,
			logic [2:0] lives);
		logic hit;
		logic in_y;
		int   left;
		hit  = 1'b0;
		in_y = (int'(y) >= LIVES_Y) && (int'(y) < LIVES_Y + LIVES_SIZE);
		for (int j = 0; j < LIVES_MAX; j++) begin
			left = base_x + j * LIVES_STEP;
			if (in_y && (j < lives) && (int'(x) >= left) && (int'(x) < left + LIVES_SIZE))
				hit = 1'b1;
		end
		return hit;
	endfunction

	// players are sampled once per frame so a frame never tears
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			p1_q <= '0;
			p2_q <= '0;
		end else if (scan.frame_start) begin
			p1_q <= p1;
			p2_q <= p2;
		end
	end

	// first pixel of a frame already sees the new values
	assign p1_cur = scan.frame_start ? p1 : p1_q;
	assign p2_cur = scan.frame_start ? p2 : p2_q;

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			hits <= '{valid: 1'b0, hs: 1'b1, vs: 1'b1, default: 1'b0};
		end else begin
			hits.valid     <= scan.valid;
			hits.hs        <= scan.hs;
			hits.vs        <= scan.vs;
			hits.p1_sprite <= scan.valid && sprite_hit(scan.x, scan.y, p1_cur);
			hits.p2_sprite <= scan.valid && sprite_hit(scan.x, scan.y, p2_cur);
			hits.p1_lives  <= scan.valid &&
				lives_hit(scan.x, scan.y, LIVES1_X, p1_cur.lives);
			hits.p2_lives  <= scan.valid &&
				lives_hit(scan.x, scan.y, LIVES2_X, p2_cur.lives);
		end
	end

endmodule

// File: source/pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor import vga_pkg::*; (
	input  logic VGA_CLK_n,
	input  logic iRST_n,
	input  hit_t hits,
	output rgb_t rgb,
	output logic blank_n,
	output logic hs,
	output logic vs
);

	rgb_t color;

	// frontmost layer wins, lives boxes sit above the sprites
	always_comb begin
		if (!hits.valid)
			color = '0;
		else if (hits.p2_lives)
			color = LIVES2_COLOR;
		else if (hits.p1_lives)
			color = LIVES1_COLOR;
		else if (hits.p2_sprite)
			color = P2_COLOR;
		else if (hits.p1_sprite)
			color = P1_COLOR;
		else
			color = BG_COLOR;
	end

	// colour and sync leave on the same edge
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			rgb     <= '0;
			blank_n <= 1'b0;
			hs      <= 1'b1;
			vs      <= 1'b1;
		end else begin
			rgb     <= color;
			blank_n <= hits.valid;
			hs      <= hits.hs;
			vs      <= hits.vs;
		end
	end

endmodule

// File: source/vga_controller.sv
`timescale 1ns/1ps

module vga_controller import vga_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33,
	parameter int LIVES1_X = 16,
	parameter int LIVES2_X = 590,
	parameter int LIVES_Y  = 16
) (
	input  logic    VGA_CLK_n,
	input  logic    iRST_n,
	input  player_t p1,
	input  player_t p2,
	output logic    blank_n,
	output logic    hs,
	output logic    vs,
	output rgb_t    rgb
);

	scan_t scan;
	hit_t  hits;

	// decode: scan timing and pixel position
	scan_decoder #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) u_decode (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.scan      (scan)
	);

	// execute: per layer hit flags
	layer_hit_unit #(
		.LIVES1_X (LIVES1_X),
		.LIVES2_X (LIVES2_X),
		.LIVES_Y  (LIVES_Y)
	) u_execute (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.scan      (scan),
		.p1        (p1),
		.p2        (p2),
		.hits      (hits)
	);

	// result: priority mux and output registers
	pixel_compositor u_result (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.hits      (hits),
		.rgb       (rgb),
		.blank_n   (blank_n),
		.hs        (hs),
		.vs        (vs)
	);

endmodule

// File: test/vga_controller_sva.sv
`timescale 1ns/1ps

module vga_controller_sva import vga_pkg::*; #(
	parameter int H_SYNC = 96
) (
	input logic VGA_CLK_n,
	input logic iRST_n,
	input logic blank_n,
	input logic hs,
	input logic vs,
	input rgb_t rgb
);

	int assert_failures = 0;

	// no picture while either sync pulse is active
	blank_during_sync: assert property (
		@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(!hs || !vs) |-> !blank_n
	) else begin
		assert_failures++;
		$error("blank_n high during a sync pulse");
	end

	// blanked pixels must be black
	black_when_blank: assert property (
		@(posedge VGA_CLK_n) disable iff (!iRST_n)
		!blank_n |-> (rgb == '0)
	) else begin
		assert_failures++;
		$error("rgb not zero while blank_n is low");
	end

	// hsync pulse width
	hs_pulse_width: assert property (
		@(posedge VGA_CLK_n) disable iff (!iRST_n)
		$fell(hs) |=> (!hs) [*H_SYNC-1] ##1 hs
	) else begin
		assert_failures++;
		$error("hs low period differs from H_SYNC cycles");
	end

endmodule

bind vga_controller vga_controller_sva #(
	.H_SYNC (H_SYNC)
) sva_inst (
	.VGA_CLK_n (VGA_CLK_n),
	.iRST_n    (iRST_n),
	.blank_n   (blank_n),
	.hs        (hs),
	.vs        (vs),
	.rgb       (rgb)
);

// File: test/vga_controller_tb.sv
`timescale 1ns/1ps

module vga_controller_tb import vga_pkg::*; ();

	// small frame, 64 cycles per line and 38 lines
	localparam int H_ACTIVE = 48;
	localparam int H_FRONT  = 4;
	localparam int H_SYNC   = 6;
	localparam int H_BACK   = 6;
	localparam int V_ACTIVE = 32;
	localparam int V_FRONT  = 2;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 2;
	localparam int LIVES1_X = 2;
	localparam int LIVES2_X = 30;
	localparam int LIVES_Y  = 1;

	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int FRAMES       = 5;
	localparam int CYCLE_LIMIT  = (FRAMES + 1) * FRAME_CYCLES + 200;

	logic    VGA_CLK_n;
	logic    iRST_n;
	player_t p1;
	player_t p2;
	logic    blank_n;
	logic    hs;
	logic    vs;
	rgb_t    rgb;

	logic [31:0] rng_state;
	int          errors = 0;
	int          compares = 0;
	int          cycles = 0;
	int          frames_done = 0;
	int          assert_errors = 0;

	// output side tracking
	player_t p1_d1, p1_d2, p2_d1, p2_d2;
	player_t p1_ref, p2_ref;
	int      out_x, out_y, run_len, runs, hs_pulses;
	logic    blank_prev, vs_prev, hs_prev, frame_pending, seen_active;

	vga_controller #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
		.LIVES1_X (LIVES1_X), .LIVES2_X (LIVES2_X), .LIVES_Y (LIVES_Y)
	) vga_controller_inst (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.p1        (p1),
		.p2        (p2),
		.blank_n   (blank_n),
		.hs        (hs),
		.vs        (vs),
		.rgb       (rgb)
	);

	initial VGA_CLK_n = 1'b0;
	always #5 VGA_CLK_n = ~VGA_CLK_n;

	function automatic logic [31:0] next_rand(logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic player_t make_player(int x, int y, int lives);
		player_t p;
		p.pos_x = coord_t'(x);
		p.pos_y = coord_t'(y);
		p.lives = 3'(lives);
		return p;
	endfunction

	// positions may run past the visible edge
	task automatic random_player(output player_t p);
		int x;
		int y;
		rng_state = next_rand(rng_state);
		x = rng_state % 56;
		rng_state = next_rand(rng_state);
		y = rng_state % 40;
		rng_state = next_rand(rng_state);
		p = make_player(x, y, rng_state % 6);
	endtask

	function automatic logic in_sprite(int x, int y, player_t p);
		int dx;
		int dy;
		dx = x - int'(p.pos_x);
		dy = y - int'(p.pos_y);
		return (dx >= 0) && (dx < SPRITE_W) && (dy >= 0) && (dy < SPRITE_H);
	endfunction

	// box index from the offset, then the gap inside each pitch
	function automatic logic in_box_row(int x, int y, int base, int lives);
		int dx;
		int idx;
		dx = x - base;
		if (dx < 0 || y < LIVES_Y || y >= LIVES_Y + LIVES_SIZE)
			return 1'b0;
		idx = dx / LIVES_STEP;
		return (idx < lives) && (idx < LIVES_MAX) && ((dx % LIVES_STEP) < LIVES_SIZE);
	endfunction

	function automatic rgb_t expected_pixel(int x, int y, player_t a, player_t b);
		if (in_box_row(x, y, LIVES2_X, int'(b.lives)))
			return LIVES2_COLOR;
		if (in_box_row(x, y, LIVES1_X, int'(a.lives)))
			return LIVES1_COLOR;
		if (in_sprite(x, y, b))
			return P2_COLOR;
		if (in_sprite(x, y, a))
			return P1_COLOR;
		return BG_COLOR;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		compares++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// frame scenarios, each set in the middle of the previous frame
	task automatic set_scenario(int f);
		case (f)
			// overlapping sprites, no boxes for p1 and all five for p2
			1: begin
				p1 = make_player(10, 8, 0);
				p2 = make_player(18, 14, 5);
			end
			// sprites right under the box rows
			2: begin
				p1 = make_player(0, 0, 3);
				p2 = make_player(28, 0, 2);
			end
			default: begin
				random_player(p1);
				random_player(p2);
			end
		endcase
	endtask

	// player inputs as seen on each rising edge
	always @(posedge VGA_CLK_n) begin
		p1_d1 <= p1;
		p1_d2 <= p1_d1;
		p2_d1 <= p2;
		p2_d2 <= p2_d1;
	end

	always @(posedge VGA_CLK_n) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			assert_errors = vga_controller_inst.sva_inst.assert_failures;
			$display("Timeout: frames did not complete within %0d cycles", CYCLE_LIMIT);
			$display("Summary: %0d compares, %0d errors, %0d assertion failures",
				compares, errors, assert_errors);
			$display("Checks failed");
			$finish;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge VGA_CLK_n) begin
		if (!iRST_n) begin
			check_value("blank_n", blank_n, 1'b0);
			check_value("hs", hs, 1'b1);
			check_value("vs", vs, 1'b1);
			check_value("rgb", rgb, '0);
			blank_prev    = 1'b0;
			vs_prev       = 1'b1;
			hs_prev       = 1'b1;
			frame_pending = 1'b1;
			seen_active   = 1'b0;
			runs          = 0;
			run_len       = 0;
			hs_pulses     = 0;
			out_x         = 0;
			out_y         = 0;
		end else begin
			if (!seen_active && !blank_n) begin
				check_value("hs", hs, 1'b1);
				check_value("vs", vs, 1'b1);
			end
			if (blank_n) begin
				seen_active = 1'b1;
				if (!blank_prev) begin
					if (frame_pending) begin
						// latch was taken one edge before this pixel left
						out_y         = 0;
						frame_pending = 1'b0;
						p1_ref        = p1_d2;
						p2_ref        = p2_d2;
					end else begin
						out_y++;
					end
					out_x   = 0;
					run_len = 0;
				end else begin
					out_x++;
				end
				run_len++;
				check_value("rgb", rgb, expected_pixel(out_x, out_y, p1_ref, p2_ref));
			end else begin
				check_value("rgb", rgb, '0);
				if (blank_prev) begin
					check_value("active run length", run_len, H_ACTIVE);
					runs++;
				end
			end
			// one hs pulse per line
			if (hs_prev && !hs)
				hs_pulses++;
			if (vs_prev && !vs) begin
				check_value("active lines per frame", runs, V_ACTIVE);
				if (frames_done > 0)
					check_value("hs pulses per frame", hs_pulses, V_TOTAL);
				runs      = 0;
				hs_pulses = 0;
				frames_done++;
			end
			if (!vs_prev && vs) begin
				check_value("vs low lines", hs_pulses, V_SYNC);
				frame_pending = 1'b1;
			end
			blank_prev = blank_n;
			vs_prev    = vs;
			hs_prev    = hs;
		end
	end

	initial begin
		iRST_n    = 1'b0;
		rng_state = 32'h1276_5fa3;
		random_player(p1);
		random_player(p2);
		repeat (2) @(negedge VGA_CLK_n);
		iRST_n = 1'b1;
		for (int f = 1; f < FRAMES; f++) begin
			if (f == 1)
				repeat (FRAME_CYCLES / 2) @(negedge VGA_CLK_n);
			else
				repeat (FRAME_CYCLES) @(negedge VGA_CLK_n);
			set_scenario(f);
		end
		wait (frames_done >= FRAMES);
		@(negedge VGA_CLK_n);
		assert_errors = vga_controller_inst.sva_inst.assert_failures;
		$display("Summary: %0d compares, %0d errors, %0d assertion failures",
			compares, errors, assert_errors);
		if (errors == 0 && assert_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: vlog.f
source/vga_pkg.sv
source/scan_decoder.sv
source/layer_hit_unit.sv
source/pixel_compositor.sv
source/vga_controller.sv
test/vga_controller_sva.sv
test/vga_controller_tb.sv

// File: Bender.yml
package:
  name: vga_controller

sources:
  - source/vga_pkg.sv
  - source/scan_decoder.sv
  - source/layer_hit_unit.sv
  - source/pixel_compositor.sv
  - source/vga_controller.sv
  - target: test
    files:
      - test/vga_controller_sva.sv
      - test/vga_controller_tb.sv
